// File: design/mcu_pkg.sv
/* Bus request and response types, address map and register offsets.
   Compiled first. Modules use scoped names in ports and import it in the body. */
package mcu_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // address map, regions selected by the top nibble
  localparam logic [31:0] SRAM_BASE   = 32'h0000_0000;
  localparam logic [31:0] AO_BASE     = 32'h2000_0000;
  localparam logic [31:0] REGION_MASK = 32'hf000_0000;

  localparam int unsigned MEM_WORDS_DEFAULT = 256;

  // always-on register offsets
  localparam logic [7:0] EXIT_OFS      = 8'h00;
  localparam logic [7:0] TIMER_CNT_OFS = 8'h04;
  localparam logic [7:0] TIMER_CMP_OFS = 8'h08;
  localparam logic [7:0] DMA_SRC_OFS   = 8'h0c;
  localparam logic [7:0] DMA_DST_OFS   = 8'h10;
  localparam logic [7:0] DMA_LEN_OFS   = 8'h14;
  localparam logic [7:0] STATUS_OFS    = 8'h18;

  // status bits, 1 and 2 are sticky and cleared by writing 1
  localparam int unsigned STATUS_BUSY_BIT  = 0;
  localparam int unsigned STATUS_DONE_BIT  = 1;
  localparam int unsigned STATUS_TIMER_BIT = 2;

endpackage

// File: design/bus_arbiter.sv
/* Round-robin arbiter for two bus masters sharing one slave port.
   Grant is combinational, the response goes back to the recorded winner. */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mcu_pkg::obi_req_t  m0_req_i,
  output mcu_pkg::obi_resp_t m0_resp_o,
  input  mcu_pkg::obi_req_t  m1_req_i,
  output mcu_pkg::obi_resp_t m1_resp_o,
  output mcu_pkg::obi_req_t  s_req_o,
  input  mcu_pkg::obi_resp_t s_resp_i
);

  logic prio_q;
  logic sel;
  logic owner_q;
  logic accept;

  // prio_q names the master that wins a tie
  always_comb begin
    if (m0_req_i.req && m1_req_i.req) begin
      sel = prio_q;
    end else begin
      sel = m1_req_i.req;
    end
  end

  assign s_req_o = sel ? m1_req_i : m0_req_i;
  assign accept  = s_req_o.req && s_resp_i.gnt;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (accept) begin
      owner_q <= sel;
      prio_q  <= ~sel;
    end
  end

  always_comb begin
    m0_resp_o.gnt    = s_resp_i.gnt && !sel && m0_req_i.req;
    m0_resp_o.rvalid = s_resp_i.rvalid && !owner_q;
    m0_resp_o.err    = s_resp_i.err && !owner_q;
    m0_resp_o.rdata  = owner_q ? 32'h0 : s_resp_i.rdata;
  end

  always_comb begin
    m1_resp_o.gnt    = s_resp_i.gnt && sel && m1_req_i.req;
    m1_resp_o.rvalid = s_resp_i.rvalid && owner_q;
    m1_resp_o.err    = s_resp_i.err && owner_q;
    m1_resp_o.rdata  = owner_q ? s_resp_i.rdata : 32'h0;
  end

endmodule

// File: design/bus_demux.sv
/* Address decoder between the arbiter and the two slaves.
   Unmapped addresses are granted at once and answered with err a cycle later. */
`timescale 1ns/1ps

module bus_demux (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mcu_pkg::obi_req_t  m_req_i,
  output mcu_pkg::obi_resp_t m_resp_o,
  output mcu_pkg::obi_req_t  sram_req_o,
  input  mcu_pkg::obi_resp_t sram_resp_i,
  output mcu_pkg::obi_req_t  ao_req_o,
  input  mcu_pkg::obi_resp_t ao_resp_i
);

  import mcu_pkg::*;

  localparam logic [1:0] TGT_SRAM = 2'd0;
  localparam logic [1:0] TGT_AO   = 2'd1;
  localparam logic [1:0] TGT_ERR  = 2'd2;

  logic       sram_hit;
  logic       ao_hit;
  logic       accept;
  logic [1:0] tgt_q;
  logic       err_q;

  assign sram_hit = (m_req_i.addr & REGION_MASK) == SRAM_BASE;
  assign ao_hit   = (m_req_i.addr & REGION_MASK) == AO_BASE;

  always_comb begin
    sram_req_o     = m_req_i;
    sram_req_o.req = m_req_i.req && sram_hit;
    ao_req_o       = m_req_i;
    ao_req_o.req   = m_req_i.req && ao_hit;
  end

  assign accept = m_req_i.req && m_resp_o.gnt;

  // target of the transfer whose response is due next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tgt_q <= TGT_SRAM;
      err_q <= 1'b0;
    end else begin
      err_q <= accept && !sram_hit && !ao_hit;
      if (accept) begin
        tgt_q <= sram_hit ? TGT_SRAM : (ao_hit ? TGT_AO : TGT_ERR);
      end
    end
  end

  always_comb begin
    if (sram_hit) begin
      m_resp_o.gnt = sram_resp_i.gnt;
    end else if (ao_hit) begin
      m_resp_o.gnt = ao_resp_i.gnt;
    end else begin
      m_resp_o.gnt = m_req_i.req;
    end
    case (tgt_q)
      TGT_SRAM: {m_resp_o.rvalid, m_resp_o.err, m_resp_o.rdata} =
        {sram_resp_i.rvalid, sram_resp_i.err, sram_resp_i.rdata};
      TGT_AO: {m_resp_o.rvalid, m_resp_o.err, m_resp_o.rdata} =
        {ao_resp_i.rvalid, ao_resp_i.err, ao_resp_i.rdata};
      default: {m_resp_o.rvalid, m_resp_o.err, m_resp_o.rdata} = {err_q, err_q, 32'h0};
    endcase
  end

endmodule

// File: design/sram_bank.sv
/* Single-port word SRAM with byte enables behind a bus slave port.
   Always grants. Read data comes back one cycle after acceptance. */
`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned MEM_WORDS = mcu_pkg::MEM_WORDS_DEFAULT
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mcu_pkg::obi_req_t  req_i,
  output mcu_pkg::obi_resp_t resp_o
);

  localparam int unsigned AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [31:0]   mem [MEM_WORDS];
  logic [AW-1:0] idx;
  logic          rvalid_q;
  logic [31:0]   rdata_q;

  // word index wraps around the bank
  assign idx = AW'(req_i.addr[31:2] % MEM_WORDS);

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.we && req_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      rdata_q <= req_i.we ? 32'h0 : mem[idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

endmodule

// File: design/dma_engine.sv
/* Word-copy DMA engine acting as a bus master.
   Started by the always-on block, copies len words one read and one write at a time. */
`timescale 1ns/1ps

module dma_engine (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  logic [31:0]       src_i,
  input  logic [31:0]       dst_i,
  input  logic [15:0]       len_i,
  output logic              busy_o,
  output logic              done_o,
  output mcu_pkg::obi_req_t  m_req_o,
  input  mcu_pkg::obi_resp_t m_resp_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD,
    S_RD_WAIT,
    S_WR,
    S_WR_WAIT
  } state_e;

  state_e      state_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [15:0] cnt_q;
  logic [31:0] data_q;
  logic        done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      src_q   <= 32'h0;
      dst_q   <= 32'h0;
      cnt_q   <= 16'h0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        S_IDLE: if (start_i) begin
          src_q <= src_i;
          dst_q <= dst_i;
          cnt_q <= len_i;
          // empty copy finishes on the spot
          if (len_i == 16'h0) done_q <= 1'b1;
          else state_q <= S_RD;
        end
        S_RD:      if (m_resp_i.gnt) state_q <= S_RD_WAIT;
        S_RD_WAIT: if (m_resp_i.rvalid) state_q <= S_WR;
        S_WR:      if (m_resp_i.gnt) state_q <= S_WR_WAIT;
        S_WR_WAIT: if (m_resp_i.rvalid) begin
          src_q <= src_q + 32'd4;
          dst_q <= dst_q + 32'd4;
          cnt_q <= cnt_q - 16'd1;
          if (cnt_q == 16'd1) begin
            state_q <= S_IDLE;
            done_q  <= 1'b1;
          end else begin
            state_q <= S_RD;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // word held between its read and its write
  always_ff @(posedge clk_i) begin
    if (state_q == S_RD_WAIT && m_resp_i.rvalid) data_q <= m_resp_i.rdata;
  end

  always_comb begin
    m_req_o.req   = (state_q == S_RD) || (state_q == S_WR);
    m_req_o.we    = state_q == S_WR;
    m_req_o.be    = 4'hf;
    m_req_o.addr  = (state_q == S_WR) ? dst_q : src_q;
    m_req_o.wdata = data_q;
  end

  assign busy_o = state_q != S_IDLE;
  assign done_o = done_q;

endmodule

// File: design/ao_peripherals.sv
/* Always-on register block with the exit register, a compare timer and DMA control.
   Sits on the bus as a slave and hosts the DMA engine as a master. */
`timescale 1ns/1ps

module ao_peripherals (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mcu_pkg::obi_req_t  req_i,
  output mcu_pkg::obi_resp_t resp_o,
  output logic [31:0]       exit_value_o,
  output logic              exit_valid_o,
  output logic              timer_irq_o,
  output logic              dma_irq_o,
  output mcu_pkg::obi_req_t  dma_req_o,
  input  mcu_pkg::obi_resp_t dma_resp_i
);

  import mcu_pkg::*;

  logic [7:0]  ofs;
  logic        wr;
  logic [31:0] exit_value_q;
  logic        exit_valid_q;
  logic [31:0] timer_cnt_q;
  logic [31:0] timer_cmp_q;
  logic        timer_pend_q;
  logic [31:0] dma_src_q;
  logic [31:0] dma_dst_q;
  logic [15:0] dma_len_q;
  logic        dma_start_q;
  logic        dma_done_q;
  logic        dma_busy;
  logic        dma_done;
  logic [31:0] status;
  logic [31:0] rd_mux;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  assign ofs = req_i.addr[7:0];
  assign wr  = req_i.req && req_i.we;

  always_comb begin
    status                   = 32'h0;
    status[STATUS_BUSY_BIT]  = dma_busy;
    status[STATUS_DONE_BIT]  = dma_done_q;
    status[STATUS_TIMER_BIT] = timer_pend_q;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      {exit_value_q, exit_valid_q, timer_cmp_q, timer_pend_q} <= '0;
      {dma_src_q, dma_dst_q, dma_len_q, dma_start_q, dma_done_q} <= '0;
      timer_cnt_q <= 32'h0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q    <= req_i.req;
      timer_cnt_q <= (wr && ofs == TIMER_CNT_OFS) ? req_i.wdata : timer_cnt_q + 32'd1;
      dma_start_q <= 1'b0;
      if (wr && ofs == EXIT_OFS) {exit_value_q, exit_valid_q} <= {req_i.wdata, 1'b1};
      if (wr && ofs == TIMER_CMP_OFS) timer_cmp_q <= req_i.wdata;
      if (wr && ofs == DMA_SRC_OFS) dma_src_q <= req_i.wdata;
      if (wr && ofs == DMA_DST_OFS) dma_dst_q <= req_i.wdata;
      // no restart while a copy is pending or running
      if (wr && ofs == DMA_LEN_OFS && !dma_busy && !dma_start_q) begin
        dma_len_q   <= req_i.wdata[15:0];
        dma_start_q <= 1'b1;
      end
      if (wr && ofs == STATUS_OFS && req_i.wdata[STATUS_TIMER_BIT]) timer_pend_q <= 1'b0;
      if (wr && ofs == STATUS_OFS && req_i.wdata[STATUS_DONE_BIT]) dma_done_q <= 1'b0;
      // a new event wins over a clear in the same cycle
      if (timer_cmp_q != 32'h0 && timer_cnt_q == timer_cmp_q) timer_pend_q <= 1'b1;
      if (dma_done) dma_done_q <= 1'b1;
    end
  end

  always_comb begin
    case (ofs)
      EXIT_OFS:      rd_mux = exit_value_q;
      TIMER_CNT_OFS: rd_mux = timer_cnt_q;
      TIMER_CMP_OFS: rd_mux = timer_cmp_q;
      DMA_SRC_OFS:   rd_mux = dma_src_q;
      DMA_DST_OFS:   rd_mux = dma_dst_q;
      DMA_LEN_OFS:   rd_mux = {16'h0, dma_len_q};
      STATUS_OFS:    rd_mux = status;
      default:       rd_mux = 32'h0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= req_i.we ? 32'h0 : rd_mux;
  end

  dma_engine dma_engine_i (
    .clk_i,
    .arst_n_i,
    .start_i (dma_start_q),
    .src_i   (dma_src_q),
    .dst_i   (dma_dst_q),
    .len_i   (dma_len_q),
    .busy_o  (dma_busy),
    .done_o  (dma_done),
    .m_req_o (dma_req_o),
    .m_resp_i(dma_resp_i)
  );

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;
  assign timer_irq_o  = timer_pend_q;
  assign dma_irq_o    = dma_done_q;

endmodule

// File: design/mini_mcu.sv
/* Top level of the bus subsystem. The host port stands in for the CPU and
   shares the system bus with the DMA. SRAM and the always-on block are the slaves. */
`timescale 1ns/1ps

module mini_mcu #(
  parameter int unsigned MEM_WORDS = mcu_pkg::MEM_WORDS_DEFAULT
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mcu_pkg::obi_req_t  host_req_i,
  output mcu_pkg::obi_resp_t host_resp_o,
  output logic [31:0]       exit_value_o,
  output logic              exit_valid_o,
  output logic              timer_irq_o,
  output logic              dma_irq_o
);

  import mcu_pkg::*;

  // dma master link
  obi_req_t  dma_req;
  obi_resp_t dma_resp;

  // shared bus after arbitration
  obi_req_t  bus_req;
  obi_resp_t bus_resp;

  // slave links
  obi_req_t  sram_req;
  obi_resp_t sram_resp;
  obi_req_t  ao_req;
  obi_resp_t ao_resp;

  bus_arbiter bus_arbiter_i (
    .clk_i,
    .arst_n_i,
    .m0_req_i (host_req_i),
    .m0_resp_o(host_resp_o),
    .m1_req_i (dma_req),
    .m1_resp_o(dma_resp),
    .s_req_o  (bus_req),
    .s_resp_i (bus_resp)
  );

  bus_demux bus_demux_i (
    .clk_i,
    .arst_n_i,
    .m_req_i    (bus_req),
    .m_resp_o   (bus_resp),
    .sram_req_o (sram_req),
    .sram_resp_i(sram_resp),
    .ao_req_o   (ao_req),
    .ao_resp_i  (ao_resp)
  );

  sram_bank #(
    .MEM_WORDS(MEM_WORDS)
  ) sram_bank_i (
    .clk_i,
    .arst_n_i,
    .req_i (sram_req),
    .resp_o(sram_resp)
  );

  ao_peripherals ao_peripherals_i (
    .clk_i,
    .arst_n_i,
    .req_i       (ao_req),
    .resp_o      (ao_resp),
    .exit_value_o,
    .exit_valid_o,
    .timer_irq_o,
    .dma_irq_o,
    .dma_req_o   (dma_req),
    .dma_resp_i  (dma_resp)
  );

endmodule

// File: dv/tb_mini_mcu.sv
/* Testbench for mini_mcu. Runs the transactions listed in dv/bus_stimulus.txt
   on the host port, driven on the falling edge, and checks responses and side outputs. */
`timescale 1ns/1ps

module tb_mini_mcu;

  import mcu_pkg::*;

  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] be;
    logic [31:0] exp;
  } stim_t;

  logic        clk;
  logic        arst_n;
  obi_req_t    host_req;
  obi_resp_t   host_resp;
  logic [31:0] exit_value;
  logic        exit_valid;
  logic        timer_irq;
  logic        dma_irq;

  stim_t       stim_q [$];
  // expected sram contents, keyed by word address
  logic [31:0] shadow [logic [29:0]];
  logic [31:0] lfsr_state = 32'hf147_a3e3;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;
  int          limit = 2000;
  bit          stim_loaded = 1'b0;
  // set while the dma competes with the host for the bus
  bit          dma_copying = 1'b0;

  mini_mcu #(
    .MEM_WORDS(256)
  ) DUT (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .host_req_i  (host_req),
    .host_resp_o (host_resp),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid),
    .timer_irq_o (timer_irq),
    .dma_irq_o   (dma_irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = 32'h0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic [31:0] reg_addr(input logic [7:0] ofs);
    return AO_BASE | {24'h0, ofs};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic load_stimulus();
    int          fd;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] b;
    logic [31:0] e;
    stim_t       s;
    fd = $fopen("dv/bus_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open dv/bus_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 3 || line.getc(0) == "#") continue;
        if ($sscanf(line, "%c %h %h %h %h", op, a, w, b, e) == 5) begin
          s = {op, a, w, b, e};
          stim_q.push_back(s);
        end else begin
          other_errors++;
          $display("malformed stimulus line: %s", line);
        end
      end
      $fclose(fd);
    end
    limit = 40 * stim_q.size() + 2000;
    stim_loaded = 1'b1;
  endtask

  // request held until the host sees its response, so no transfer is taken twice
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata, output logic err);
    int extra;
    extra = 0;
    @(negedge clk);
    host_req = {1'b1, we, be, addr, wdata};
    @(negedge clk);
    while (!host_resp.rvalid) begin
      @(negedge clk);
      extra++;
    end
    rdata    = host_resp.rdata;
    err      = host_resp.err;
    host_req = '0;
    // an idle bus grants at once and answers one cycle later
    assert (dma_copying || extra == 0) else begin
      other_errors++;
      $display("host transfer at %h waited %0d extra cycles on an idle bus", addr, extra);
    end
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    logic [29:0] key;
    key = addr[31:2];
    bus_access(1'b1, addr, wdata, be, rdata, err);
    check_value($sformatf("write err at %h", addr), {31'h0, err}, 32'h0);
    if ((addr & REGION_MASK) == SRAM_BASE) begin
      shadow[key] = merge_lanes(shadow.exists(key) ? shadow[key] : 32'h0, wdata, be);
    end
  endtask

  task automatic host_read_expect(input logic [31:0] addr, input logic [31:0] exp,
                                  input string what);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, addr, 32'h0, 4'hf, rdata, err);
    check_value($sformatf("%s at %h", what, addr), rdata, exp);
    check_value($sformatf("%s err at %h", what, addr), {31'h0, err}, 32'h0);
  endtask

  task automatic run_dma_check(input stim_t s);
    logic [31:0] src_words [$];
    logic [31:0] word;
    logic [31:0] addr;
    int          len;
    int          k;
    len = s.be;
    for (int i = 0; i < len; i++) begin
      take_bits(32, word);
      src_words.push_back(word);
      host_write(s.addr + 32'(4 * i), word, 4'hf);
    end
    for (int i = 0; i < 4; i++) begin
      take_bits(32, word);
      host_write(s.exp + 32'(4 * i), word, 4'hf);
    end
    host_write(reg_addr(DMA_SRC_OFS), s.addr, 4'hf);
    host_write(reg_addr(DMA_DST_OFS), s.wdata, 4'hf);
    host_write(reg_addr(DMA_LEN_OFS), len, 4'hf);
    dma_copying = 1'b1;
    // host traffic on scratch words competes with the copy
    k = 0;
    while (!dma_irq) begin
      addr = s.exp + 32'(4 * (k % 4));
      host_read_expect(addr, shadow[addr[31:2]], "scratch read during copy");
      k++;
    end
    dma_copying = 1'b0;
    for (int i = 0; i < len; i++) begin
      addr = s.wdata + 32'(4 * i);
      host_read_expect(addr, src_words[i], "dma destination");
      shadow[addr[31:2]] = src_words[i];
    end
    host_write(reg_addr(STATUS_OFS), 32'h1 << STATUS_DONE_BIT, 4'hf);
    check_value("dma_irq_o after clear", {31'h0, dma_irq}, 32'h0);
  endtask

  task automatic run_timer_check();
    logic [31:0] cnt;
    logic [31:0] rdata;
    logic        err;
    int          waited;
    bus_access(1'b0, reg_addr(TIMER_CNT_OFS), 32'h0, 4'hf, cnt, err);
    host_write(reg_addr(TIMER_CMP_OFS), cnt + 32'd50, 4'hf);
    waited = 0;
    while (!timer_irq && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    assert (timer_irq) else begin
      other_errors++;
      $display("timer interrupt did not rise within 200 cycles of the compare write");
    end
    bus_access(1'b0, reg_addr(STATUS_OFS), 32'h0, 4'hf, rdata, err);
    check_value("STATUS timer bit while pending", {31'h0, rdata[STATUS_TIMER_BIT]}, 32'h1);
    host_write(reg_addr(STATUS_OFS), 32'h1 << STATUS_TIMER_BIT, 4'hf);
    check_value("timer_irq_o after clear", {31'h0, timer_irq}, 32'h0);
    bus_access(1'b0, reg_addr(STATUS_OFS), 32'h0, 4'hf, rdata, err);
    check_value("STATUS timer bit after clear", {31'h0, rdata[STATUS_TIMER_BIT]}, 32'h0);
  endtask

  task automatic run_line(input stim_t s);
    logic [31:0] rdata;
    logic        err;
    case (s.op)
      "W": host_write(s.addr, s.wdata, s.be[3:0]);
      "R": host_read_expect(s.addr, s.exp, "read");
      "M": host_read_expect(s.addr, shadow[s.addr[31:2]], "merged read");
      "E": begin
        bus_access(1'b0, s.addr, 32'h0, 4'hf, rdata, err);
        check_value($sformatf("unmapped err at %h", s.addr), {31'h0, err}, 32'h1);
        check_value($sformatf("unmapped rdata at %h", s.addr), rdata, 32'h0);
      end
      "D": run_dma_check(s);
      "T": run_timer_check();
      "X": begin
        host_write(s.addr, s.wdata, s.be[3:0]);
        check_value("exit_valid_o", {31'h0, exit_valid}, 32'h1);
        check_value("exit_value_o", exit_value, s.wdata);
      end
      default: begin
        other_errors++;
        $display("unknown stimulus operation '%c'", s.op);
      end
    endcase
  endtask

  // watchdog, limit scales with the stimulus length
  initial begin
    wait (stim_loaded);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    other_errors++;
    $display("timeout: run did not finish within %0d cycles", limit);
    report_and_finish();
  end

  initial begin
    logic [31:0] gap;
    host_req = '0;
    arst_n   = 1'b0;
    load_stimulus();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_value("gnt and rvalid after reset", {30'h0, host_resp.gnt, host_resp.rvalid}, 32'h0);
    check_value("exit and irqs after reset", {29'h0, exit_valid, timer_irq, dma_irq}, 32'h0);
    foreach (stim_q[i]) begin
      take_bits(2, gap);
      repeat (gap[1:0]) @(negedge clk);
      run_line(stim_q[i]);
    end
    report_and_finish();
  end

endmodule

// File: project.f
design/mcu_pkg.sv
design/bus_arbiter.sv
design/bus_demux.sv
design/sram_bank.sv
design/dma_engine.sv
design/ao_peripherals.sv
design/mini_mcu.sv
dv/tb_mini_mcu.sv

// File: run_sim.sh
#!/bin/sh
# build the mini_mcu testbench with Verilator, run it, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mini_mcu -f project.f \
  && ./obj_dir/Vtb_mini_mcu | tee sim.log
grep -qx "Simulation PASSED" sim.log \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail, see sim.log"; exit 1; }

// File: dv/bus_stimulus.txt
# op addr wdata be exp (hex) W write, R read vs exp, M read vs merged model, E unmapped read
# D addr=src wdata=dst be=words exp=scratch base, T timer test, X exit write (last line)
W 00000010 11223344 f 00000000
W 00000014 a5a5a5a5 f 00000000
R 00000010 00000000 0 11223344
R 00000014 00000000 0 a5a5a5a5
W 00000010 000000ee 1 00000000
W 00000014 bbaa0000 c 00000000
M 00000010 00000000 0 00000000
M 00000014 00000000 0 00000000
R 00000014 00000000 0 bbaaa5a5
E 40000000 00000000 0 00000000
R 00000010 00000000 0 112233ee
D 00000100 00000200 8 00000040
T 00000000 00000000 0 00000000
X 20000000 0000c0de f 00000000
